//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module routerOutputPortTb \
  -f tb.f -Mdir obj_dir -o simv
./obj_dir/simv 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log
then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- source/arbPkg.sv
package arbPkg;

  import nocPkg::*;

  // one-hot, bit i+1 owns port i.
  typedef enum logic [5:0]
  {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState_e;

  localparam int countWidth = lengthWidth; // counter reaches any length value.

endpackage

//--- source/grantTimer.sv
module grantTimer
  import nocPkg::*, arbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [countWidth-1:0] limit;
  logic [countWidth-1:0] count;

  // any header on this input sets the limit, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == flitHeader)
    begin
      limit <= length;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1; // owner kept the channel another cycle.
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- source/nocPkg.sv
package nocPkg;

  // one output channel fed by five mesh inputs.
  localparam int numPorts = 5;

  localparam int flitWidth   = 16;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12; // low bits of a header word.

  // flit id codes.
  localparam logic [flitIdWidth-1:0] flitHeader = 3'd1;
  localparam logic [flitIdWidth-1:0] flitBody   = 3'd2;
  localparam logic [flitIdWidth-1:0] flitTail   = 3'd3;

  // array index of each input, also the rotation order.
  typedef enum logic [2:0]
  {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdx_e;

endpackage

//--- source/outputStage.sv
module outputStage
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [numPorts-1:0]    grant,
  input  logic                   req      [numPorts],
  input  logic [flitIdWidth-1:0] flitId   [numPorts],
  input  logic [flitWidth-1:0]   flitData [numPorts],
  output logic                   outValid,
  output portIdx_e               outPort,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [flitWidth-1:0]   outData
);

  portIdx_e sel;
  logic     selActive;

  // grant is one-hot, so at most one index matches.
  always_comb
  begin
    sel = portLocal;
    selActive = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        sel = portIdx_e'(i);
        selActive = req[i]; // owner still has a flit up.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selActive;
    end
  end

  always_ff @(posedge clk)
  begin
    outPort <= sel;
    outFlitId <= flitId[sel];
    outData <= flitData[sel];
  end

endmodule

//--- source/routerOutputPort.sv
module routerOutputPort
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req      [numPorts],
  input  logic [flitIdWidth-1:0] flitId   [numPorts],
  input  logic [flitWidth-1:0]   flitData [numPorts],
  output logic                   outValid,
  output portIdx_e               outPort,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [flitWidth-1:0]   outData
);

  logic [numPorts-1:0] grant; // one-hot owner, zero when idle.

  switchArbiter u_switchArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .flitData (flitData),
    .grant    (grant)
  );

  // one register stage after the grant.
  outputStage u_outputStage
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .req       (req),
    .flitId    (flitId),
    .flitData  (flitData),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

endmodule

//--- source/switchArbiter.sv
module switchArbiter
  import nocPkg::*, arbPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req      [numPorts],
  input  logic [flitIdWidth-1:0] flitId   [numPorts],
  input  logic [flitWidth-1:0]   flitData [numPorts],
  output logic [numPorts-1:0]    grant
);

  arbState_e           state;
  arbState_e           nextState;
  portIdx_e            owner;
  logic                ownerValid;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  // state that owns port p.
  function automatic arbState_e portState(input int p);
    return arbState_e'(6'b000010 << p);
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : genTimer
    grantTimer u_grantTimer
    (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitId[i]),
      .length   (flitData[i][lengthWidth-1:0]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // which port the current state owns, if any.
  always_comb
  begin
    owner = portLocal;
    ownerValid = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (state[i + 1])
      begin
        owner = portIdx_e'(i);
        ownerValid = 1'b1;
      end
    end
  end

  always_comb
  begin : nextLogic
    int   cand;
    logic found;

    nextState = stIdle;
    runTimer = '0;
    found = 1'b0;
    cand = 0;
    if (!ownerValid)
    begin
      // from idle the lowest index wins.
      for (int k = 0; k < numPorts; k++)
      begin
        if (!found && req[k])
        begin
          nextState = portState(k);
          found = 1'b1;
        end
      end
    end
    else if (req[owner] && !timesUp[owner])
    begin
      nextState = state;
      runTimer[owner] = 1'b1; // owner keeps its share.
    end
    else
    begin
      // search after the owner, owner itself comes last.
      for (int k = 1; k <= numPorts; k++)
      begin
        cand = (int'(owner) + k) % numPorts;
        if (!found && req[cand])
        begin
          nextState = portState(cand);
          found = 1'b1;
        end
      end
    end
  end

  assign grant = state[numPorts:1]; // zero while idle.

endmodule

//--- tb.f
source/nocPkg.sv
source/arbPkg.sv
source/grantTimer.sv
source/switchArbiter.sv
source/outputStage.sv
source/routerOutputPort.sv
tb/switchArbiter_assert.sv
tb/outputChecker.sv
tb/routerOutputPortTb.sv

//--- tb/outputChecker.sv
module outputChecker
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req      [numPorts],
  input  logic [flitIdWidth-1:0] flitId   [numPorts],
  input  logic [flitWidth-1:0]   flitData [numPorts],
  input  logic                   outValid,
  input  portIdx_e               outPort,
  input  logic [flitIdWidth-1:0] outFlitId,
  input  logic [flitWidth-1:0]   outData,
  output int                     errors
);

  int                     owner; // -1 while idle.
  logic [lengthWidth-1:0] count [numPorts];
  logic [lengthWidth-1:0] limit [numPorts];
  logic                   armed;
  logic                   expValid;
  portIdx_e               expPort;
  logic [flitIdWidth-1:0] expId;
  logic [flitWidth-1:0]   expData;

  initial
  begin
    errors = 0;
    armed = 1'b0;
  end

  // rotating priority, the current owner comes last.
  function automatic int nextOwner(input int cur, input logic [numPorts-1:0] reqs,
                                   input logic stay);
    int pick;
    pick = -1;
    if (cur < 0)
    begin
      for (int k = numPorts - 1; k >= 0; k--)
        if (reqs[k]) pick = k;
    end
    else if (stay)
      pick = cur;
    else
    begin
      for (int k = numPorts; k >= 1; k--)
        if (reqs[(cur + k) % numPorts]) pick = (cur + k) % numPorts;
    end
    return pick;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk)
  begin : compare
    logic [numPorts-1:0] reqs;
    logic                stay;
    if (armed)
    begin
      checkValue("outValid", 32'(outValid), 32'(expValid));
      if (expValid)
      begin
        checkValue("outPort", 32'(outPort), 32'(expPort));
        checkValue("outFlitId", 32'(outFlitId), 32'(expId));
        checkValue("outData", 32'(outData), 32'(expData));
      end
    end
    if (rst)
    begin
      owner = -1;
      expValid = 1'b0;
      armed = 1'b1;
      for (int p = 0; p < numPorts; p++)
      begin
        count[p] = '0;
        limit[p] = '0;
      end
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
        reqs[p] = req[p];
      // output register takes the owner's flit from this edge.
      expValid = (owner >= 0) && reqs[owner];
      if (owner >= 0)
      begin
        expPort = portIdx_e'(owner);
        expId = flitId[owner];
        expData = flitData[owner];
      end
      stay = (owner >= 0) && reqs[owner] && (count[owner] != limit[owner]);
      for (int p = 0; p < numPorts; p++)
      begin
        count[p] = (stay && p == owner) ? count[p] + 1'b1 : '0;
        if (flitId[p] == flitHeader)
          limit[p] = flitData[p][lengthWidth-1:0];
      end
      owner = nextOwner(owner, reqs, stay);
    end
  end

endmodule

//--- tb/routerOutputPortTb.sv
module routerOutputPortTb;
  import nocPkg::*;

  logic                   clk;
  logic                   rst;
  logic                   req      [numPorts];
  logic [flitIdWidth-1:0] flitId   [numPorts];
  logic [flitWidth-1:0]   flitData [numPorts];
  logic                   outValid;
  portIdx_e               outPort;
  logic [flitIdWidth-1:0] outFlitId;
  logic [flitWidth-1:0]   outData;

  int   stage    [numPorts]; // 0 gap, 1 header, 2 body, 3 tail.
  int   bodyLeft [numPorts];
  int   gapLeft  [numPorts];
  int   holdLeft [numPorts];
  int   waitCnt  [numPorts];
  int   errCount;
  int   timeouts;
  int   packets;
  logic newPackets;

  routerOutputPort u_routerOutputPort
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitId    (flitId),
    .flitData  (flitData),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

  outputChecker u_outputChecker
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitId    (flitId),
    .flitData  (flitData),
    .outValid  (outValid),
    .outPort   (outPort),
    .outFlitId (outFlitId),
    .outData   (outData),
    .errors    (errCount)
  );

  always #20 clk = ~clk;

  task automatic loadFlit(input int p);
    if (stage[p] == 1)
    begin
      flitId[p] = flitHeader;
      flitData[p] = {4'($urandom), 12'($urandom % 7)}; // length 0 to 6.
    end
    else
    begin
      flitId[p] = (stage[p] == 2) ? flitBody : flitTail;
      flitData[p] = 16'($urandom);
    end
  endtask

  // one cycle of traffic on every input.
  task automatic stepPorts();
    logic sent;
    for (int p = 0; p < numPorts; p++)
    begin
      sent = req[p] && outValid && (outPort == portIdx_e'(p));
      if (stage[p] == 0)
      begin
        if (gapLeft[p] > 0)
          gapLeft[p]--;
        else if (newPackets)
        begin
          stage[p] = 1;
          bodyLeft[p] = $urandom % 8;
          holdLeft[p] = 1 + $urandom % 10;
          waitCnt[p] = 0;
          req[p] = 1'b1;
          loadFlit(p);
        end
      end
      else if (sent)
      begin
        waitCnt[p] = 0;
        if (stage[p] == 3)
        begin
          stage[p] = 0; // tail went out.
          req[p] = 1'b0;
          flitId[p] = '0;
          gapLeft[p] = $urandom % 6;
          packets++;
        end
        else
        begin
          if (stage[p] == 2)
            bodyLeft[p]--;
          stage[p] = (bodyLeft[p] > 0) ? 2 : 3;
          loadFlit(p);
          holdLeft[p]--;
          if (holdLeft[p] == 0)
          begin
            req[p] = 1'b0; // owner lets go mid-packet.
            gapLeft[p] = 1 + $urandom % 3;
          end
        end
      end
      else if (!req[p])
      begin
        gapLeft[p]--;
        if (gapLeft[p] == 0)
        begin
          req[p] = 1'b1;
          holdLeft[p] = 1 + $urandom % 10;
        end
      end
      else
      begin
        waitCnt[p]++;
        if (waitCnt[p] > 200)
        begin
          $display("timeout: port %0d waited over 200 cycles for its flit", p);
          timeouts++;
          waitCnt[p] = 0;
        end
      end
    end
  endtask

  function automatic logic anyBusy();
    logic busy;
    busy = outValid;
    for (int p = 0; p < numPorts; p++)
      if (stage[p] != 0) busy = 1'b1;
    return busy;
  endfunction

  initial
  begin
    logic busy;
    void'($urandom(32'he6b0));
    clk = 1'b0;
    rst = 1'b1;
    newPackets = 1'b0;
    timeouts = 0;
    packets = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      req[p] = 1'b0;
      flitId[p] = '0;
      flitData[p] = '0;
      stage[p] = 0;
      bodyLeft[p] = 0;
      gapLeft[p] = 0; // all inputs start together.
      holdLeft[p] = 0;
      waitCnt[p] = 0;
    end
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    repeat (10) @(posedge clk); // idle channel.
    newPackets = 1'b1;
    for (int n = 0; n < 3000; n++)
    begin
      @(posedge clk);
      #2 stepPorts();
    end
    newPackets = 1'b0;
    busy = 1'b1;
    for (int n = 0; n < 300 && busy; n++)
    begin
      @(posedge clk);
      #2 stepPorts();
      busy = anyBusy();
    end
    if (busy)
    begin
      $display("timeout: traffic did not drain within 300 cycles");
      timeouts++;
    end
    repeat (3) @(posedge clk);
    #2;
    $display("closing: %0d value errors, %0d timeouts, %0d packets", errCount, timeouts,
             packets);
    if (errCount == 0 && timeouts == 0 && packets > 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- tb/switchArbiter_assert.sv
module switchArbiterAssert
  import nocPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                req      [numPorts],
  input logic [numPorts-1:0] grant,
  input logic [numPorts-1:0] runTimer
);

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set");

  // only the owner may keep its timer running.
  assert property (@(posedge clk) disable iff (rst) (runTimer & ~grant) == '0)
    else $error("runTimer set for a port without grant");

  for (genvar i = 0; i < numPorts; i++)
  begin : genRelease
    assert property (@(posedge clk) disable iff (rst) (grant[i] && !req[i]) |=> !grant[i])
      else $error("port %0d kept its grant after dropping req", i);
  end

endmodule

bind switchArbiter switchArbiterAssert u_switchArbiterAssert
(
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .grant    (grant),
  .runTimer (runTimer)
);
